// ==== hdl/cpuTypesPkg.sv ====
// Shared types for the pipeline back end.
// Opcode and function code enums, ALU operations,
// R-type and I-type instruction views with their union,
// data memory size and the JAL link register.

package cpuTypesPkg;

  // ####################################################################
  // Sizes and fixed registers
  // ####################################################################
  localparam int DMEM_WORDS = 64;              // Words of data memory.
  localparam logic [4:0] LINK_REG = 5'd31;     // JAL destination.

  // ####################################################################
  // Encodings
  // ####################################################################
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_JAL   = 6'h03,
    OP_ADDIU = 6'h09,
    OP_SLTI  = 6'h0A,
    OP_SLTIU = 6'h0B,
    OP_ANDI  = 6'h0C,
    OP_ORI   = 6'h0D,
    OP_XORI  = 6'h0E,
    OP_LUI   = 6'h0F,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2B
  } opcodeT;

  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_NOR  = 6'h27,
    FN_SLT  = 6'h2A,
    FN_SLTU = 6'h2B
  } functT;

  typedef enum logic [3:0] {
    ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
    ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
  } aluOpT;

  // Same word, two field layouts.
  typedef struct packed {
    opcodeT     opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    functT      funct;
  } rTypeT;

  typedef struct packed {
    opcodeT      opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iTypeT;

  typedef union packed {
    rTypeT rType;
    iTypeT iType;
  } instrT;

endpackage

// ==== hdl/pipeRegIf.sv ====
// Pipeline stage record interface.
// Control bits, instruction and data fields of one stage,
// with a producer modport and a register-input modport.

`timescale 1ns/10ps

interface pipeRegIf;
  import cpuTypesPkg::*;

  logic        valid;        // Record holds an instruction.
  logic        WEN;          // Register write.
  logic        regDst;       // rd when set, else rt.
  logic        memToReg;     // Load data to register.
  logic        dREN;
  logic        dWEN;
  logic        jl;           // Jump and link.
  instrT       instr;
  logic [31:0] incPC;
  logic [31:0] rdat1;
  logic [31:0] rdat2;        // Also store data.
  logic [31:0] outputPort;   // ALU result.
  logic [31:0] dmemload;     // Loaded word.

  // Producing side drives the whole record.
  modport stage (
    output valid, WEN, regDst, memToReg, dREN, dWEN, jl,
    output instr, incPC, rdat1, rdat2, outputPort, dmemload
  );

  // Register or consuming side reads it.
  modport regSide (
    input valid, WEN, regDst, memToReg, dREN, dWEN, jl,
    input instr, incPC, rdat1, rdat2, outputPort, dmemload
  );

endinterface

// ==== hdl/controlUnit.sv ====
// Control unit.
// Opcode and function decode into register, memory and ALU controls.

`timescale 1ns/10ps

module controlUnit (
  input  cpuTypesPkg::instrT instr,
  pipeRegIf.stage            ctrlOut,
  output cpuTypesPkg::aluOpT aluOp,
  output logic               aluSrc,
  output logic               zeroExt,
  output logic               lui
);
  import cpuTypesPkg::*;

  always_comb begin
    ctrlOut.WEN      = 1'b0;       // Unknown opcodes keep everything off.
    ctrlOut.regDst   = 1'b0;
    ctrlOut.memToReg = 1'b0;
    ctrlOut.dREN     = 1'b0;
    ctrlOut.dWEN     = 1'b0;
    ctrlOut.jl       = 1'b0;
    aluOp            = ALU_ADD;
    aluSrc           = 1'b0;
    zeroExt          = 1'b0;
    lui              = 1'b0;

    case (instr.rType.opcode)
      OP_RTYPE: begin
        ctrlOut.WEN    = 1'b1;
        ctrlOut.regDst = 1'b1;
        case (instr.rType.funct)
          FN_SLL:  aluOp = ALU_SLL;
          FN_SRL:  aluOp = ALU_SRL;
          FN_ADDU: aluOp = ALU_ADD;
          FN_SUBU: aluOp = ALU_SUB;
          FN_AND:  aluOp = ALU_AND;
          FN_OR:   aluOp = ALU_OR;
          FN_XOR:  aluOp = ALU_XOR;
          FN_NOR:  aluOp = ALU_NOR;
          FN_SLT:  aluOp = ALU_SLT;
          FN_SLTU: aluOp = ALU_SLTU;
          default: ctrlOut.WEN = 1'b0;   // Unsupported function.
        endcase
      end
      OP_ADDIU, OP_SLTI, OP_SLTIU: begin
        ctrlOut.WEN = 1'b1;
        aluSrc      = 1'b1;              // Sign-extended immediate.
        if (instr.rType.opcode == OP_SLTI) aluOp = ALU_SLT;
        else if (instr.rType.opcode == OP_SLTIU) aluOp = ALU_SLTU;
      end
      OP_ANDI, OP_ORI, OP_XORI: begin
        ctrlOut.WEN = 1'b1;
        aluSrc      = 1'b1;
        zeroExt     = 1'b1;              // Logical ops zero-extend.
        if (instr.rType.opcode == OP_ANDI) aluOp = ALU_AND;
        else if (instr.rType.opcode == OP_ORI) aluOp = ALU_OR;
        else aluOp = ALU_XOR;
      end
      OP_LUI: begin
        ctrlOut.WEN = 1'b1;
        aluSrc      = 1'b1;
        lui         = 1'b1;
      end
      OP_LW: begin
        ctrlOut.WEN      = 1'b1;
        ctrlOut.memToReg = 1'b1;
        ctrlOut.dREN     = 1'b1;
        aluSrc           = 1'b1;         // Base plus offset.
      end
      OP_SW: begin
        ctrlOut.dWEN = 1'b1;
        aluSrc       = 1'b1;
      end
      OP_JAL: begin
        ctrlOut.WEN = 1'b1;
        ctrlOut.jl  = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== hdl/executeStage.sv ====
// Execute stage.
// Immediate extension, second operand select, ALU and LUI,
// and the data half of the EX record.

`timescale 1ns/10ps

module executeStage (
  input  cpuTypesPkg::aluOpT aluOp,
  input  logic               aluSrc,
  input  logic               zeroExt,
  input  logic               lui,
  input  cpuTypesPkg::instrT instr,
  input  logic [31:0]        incPC,
  input  logic [31:0]        rdat1,
  input  logic [31:0]        rdat2,
  input  logic               inValid,
  pipeRegIf.stage            exOut
);
  import cpuTypesPkg::*;

  logic [31:0] immExt;     // Extended immediate.
  logic [31:0] opB;        // Second ALU operand.
  logic [31:0] aluRes;

  // ####################################################################
  // Operands
  // ####################################################################
  assign immExt = zeroExt ? {16'h0000, instr.iType.imm}
                          : {{16{instr.iType.imm[15]}}, instr.iType.imm};
  assign opB    = aluSrc ? immExt : rdat2;

  // ####################################################################
  // ALU
  // ####################################################################
  always_comb begin
    case (aluOp)
      ALU_SLL:  aluRes = rdat2 << instr.rType.shamt;   // Shifts act on rt.
      ALU_SRL:  aluRes = rdat2 >> instr.rType.shamt;
      ALU_ADD:  aluRes = rdat1 + opB;
      ALU_SUB:  aluRes = rdat1 - opB;
      ALU_AND:  aluRes = rdat1 & opB;
      ALU_OR:   aluRes = rdat1 | opB;
      ALU_XOR:  aluRes = rdat1 ^ opB;
      ALU_NOR:  aluRes = ~(rdat1 | opB);
      ALU_SLT:  aluRes = {31'd0, $signed(rdat1) < $signed(opB)};
      ALU_SLTU: aluRes = {31'd0, rdat1 < opB};
      default:  aluRes = 32'd0;
    endcase
  end

  // Record fields owned by this stage.
  assign exOut.valid      = inValid;
  assign exOut.instr      = instr;
  assign exOut.incPC      = incPC;                 // JAL link value.
  assign exOut.rdat1      = rdat1;
  assign exOut.rdat2      = rdat2;                 // Store data.
  assign exOut.outputPort = lui ? {instr.iType.imm, 16'h0000} : aluRes;
  assign exOut.dmemload   = 32'd0;                 // Filled in MEM.

endmodule

// ==== hdl/pipeStageReg.sv ====
// Pipeline stage register.
// Enabled copy of a stage record with bubble insertion,
// used for both EX/MEM and MEM/WB.

`timescale 1ns/10ps

module pipeStageReg (
  input logic       CLK,
  input logic       nRST,
  input logic       enable,
  pipeRegIf.regSide prIn,
  pipeRegIf.stage   prOut
);

  // Control half, cleared on reset and on an invalid input.
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      prOut.valid    <= 1'b0;
      prOut.WEN      <= 1'b0;
      prOut.regDst   <= 1'b0;
      prOut.memToReg <= 1'b0;
      prOut.dREN     <= 1'b0;
      prOut.dWEN     <= 1'b0;
      prOut.jl       <= 1'b0;
    end else if (enable) begin
      prOut.valid    <= prIn.valid;
      prOut.WEN      <= prIn.valid & prIn.WEN;        // Bubble has no effect.
      prOut.regDst   <= prIn.valid & prIn.regDst;
      prOut.memToReg <= prIn.valid & prIn.memToReg;
      prOut.dREN     <= prIn.valid & prIn.dREN;
      prOut.dWEN     <= prIn.valid & prIn.dWEN;
      prOut.jl       <= prIn.valid & prIn.jl;
    end
  end

  // Payload half.
  always_ff @(posedge CLK) begin
    if (enable) begin
      prOut.instr      <= prIn.instr;
      prOut.incPC      <= prIn.incPC;
      prOut.rdat1      <= prIn.rdat1;
      prOut.rdat2      <= prIn.rdat2;
      prOut.outputPort <= prIn.outputPort;
      prOut.dmemload   <= prIn.dmemload;
    end
  end

  // A stalled register keeps its whole record.
  property holdWhileStalled;
    @(posedge CLK) disable iff (!nRST)
      !enable |=> $stable({prOut.valid, prOut.WEN, prOut.regDst, prOut.memToReg,
                           prOut.dREN, prOut.dWEN, prOut.jl, prOut.instr,
                           prOut.incPC, prOut.rdat1, prOut.rdat2,
                           prOut.outputPort, prOut.dmemload});
  endproperty
  assert property (holdWhileStalled)
    else $error("Stage record changed while stalled.");

endmodule

// ==== hdl/memoryStage.sv ====
// Memory stage.
// Word-addressed data memory, asynchronous read and clocked write,
// plus the pass-through of the MEM record.

`timescale 1ns/10ps

module memoryStage (
  input logic       CLK,
  input logic       nRST,
  input logic       enable,
  pipeRegIf.regSide memIn,
  pipeRegIf.stage   memOut
);
  import cpuTypesPkg::*;

  logic [31:0] dmem [DMEM_WORDS];   // Data memory.
  logic [5:0]  dAddr;               // Word index.
  logic        storeNow;

  assign dAddr    = memIn.outputPort[7:2];
  assign storeNow = enable & memIn.valid & memIn.dWEN;   // Held under stall.

  // ####################################################################
  // Storage
  // ####################################################################
  always_ff @(posedge CLK) begin
    if (storeNow) begin
      dmem[dAddr] <= memIn.rdat2;
    end
  end

  assign memOut.dmemload = dmem[dAddr];   // Async read.

  // Rest of the record passes on to MEM/WB.
  assign memOut.valid      = memIn.valid;
  assign memOut.WEN        = memIn.WEN;
  assign memOut.regDst     = memIn.regDst;
  assign memOut.memToReg   = memIn.memToReg;
  assign memOut.dREN       = memIn.dREN;
  assign memOut.dWEN       = memIn.dWEN;
  assign memOut.jl         = memIn.jl;
  assign memOut.instr      = memIn.instr;
  assign memOut.incPC      = memIn.incPC;
  assign memOut.rdat1      = memIn.rdat1;
  assign memOut.rdat2      = memIn.rdat2;
  assign memOut.outputPort = memIn.outputPort;

  // Decode never asks for a read and a write together.
  property noReadWrite;
    @(posedge CLK) disable iff (!nRST)
      !(memIn.dREN && memIn.dWEN);
  endproperty
  assert property (noReadWrite)
    else $error("Memory read and write requested together.");

endmodule

// ==== hdl/writebackStage.sv ====
// Write-back stage.
// Destination and data select for the retire port,
// with register 0 writes suppressed.

`timescale 1ns/10ps

module writebackStage (
  pipeRegIf.regSide   wbIn,
  output logic        retValid,
  output logic        retWen,
  output logic [4:0]  retAddr,
  output logic [31:0] retData
);
  import cpuTypesPkg::*;

  logic [4:0] dstReg;    // rd or rt.

  assign dstReg = wbIn.regDst ? wbIn.instr.rType.rd : wbIn.instr.rType.rt;

  assign retValid = wbIn.valid;                        // Bubbles never retire.
  assign retAddr  = wbIn.jl ? LINK_REG : dstReg;
  assign retData  = wbIn.jl       ? wbIn.incPC :
                    wbIn.memToReg ? wbIn.dmemload : wbIn.outputPort;
  assign retWen   = wbIn.valid & wbIn.WEN & (retAddr != 5'd0);

endmodule

// ==== hdl/pipelineBackEnd.sv ====
// Pipeline back end top level.
// Decode and execute, EX/MEM register, data memory, MEM/WB register
// and write-back, with a single stall enable from the retire handshake.

`timescale 1ns/10ps

module pipelineBackEnd (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               inValid,
  output logic               inReady,
  input  cpuTypesPkg::instrT instr,
  input  logic [31:0]        incPC,
  input  logic [31:0]        rdat1,
  input  logic [31:0]        rdat2,
  output logic               retValid,
  input  logic               retReady,
  output logic               retWen,
  output logic [4:0]         retAddr,
  output logic [31:0]        retData
);
  import cpuTypesPkg::*;

  logic  enable;     // Advances both registers.
  aluOpT aluOp;
  logic  aluSrc;
  logic  zeroExt;
  logic  lui;

  pipeRegIf exOut ();
  pipeRegIf memIn ();
  pipeRegIf memOut ();
  pipeRegIf wbIn ();

  // Stall only when a retiring record is refused.
  assign enable  = ~retValid | retReady;
  assign inReady = enable;

  // ####################################################################
  // Stages
  // ####################################################################
  controlUnit ctrl (
    .instr   (instr),
    .ctrlOut (exOut),
    .aluOp   (aluOp),
    .aluSrc  (aluSrc),
    .zeroExt (zeroExt),
    .lui     (lui)
  );

  executeStage exec (
    .aluOp   (aluOp),
    .aluSrc  (aluSrc),
    .zeroExt (zeroExt),
    .lui     (lui),
    .instr   (instr),
    .incPC   (incPC),
    .rdat1   (rdat1),
    .rdat2   (rdat2),
    .inValid (inValid),
    .exOut   (exOut)
  );

  pipeStageReg exMemReg (.CLK(CLK), .nRST(nRST), .enable(enable), .prIn(exOut), .prOut(memIn));

  memoryStage mem (.CLK(CLK), .nRST(nRST), .enable(enable), .memIn(memIn), .memOut(memOut));

  pipeStageReg memWbReg (.CLK(CLK), .nRST(nRST), .enable(enable), .prIn(memOut), .prOut(wbIn));

  writebackStage wb (
    .wbIn     (wbIn),
    .retValid (retValid),
    .retWen   (retWen),
    .retAddr  (retAddr),
    .retData  (retData)
  );

  // Refused retire keeps the port steady until taken.
  property retireHeld;
    @(posedge CLK) disable iff (!nRST)
      retValid && !retReady |=> $stable({retValid, retWen, retAddr, retData});
  endproperty
  assert property (retireHeld)
    else $error("Retire port changed under back-pressure.");

endmodule

// ==== verification/backEndTb.sv ====
// Testbench for the pipeline back end.
// Reference model with a data memory copy, random stimulus,
// retire checker with latency and stall checks, and timeouts.

`timescale 1ns/10ps

module backEndTb;
  import cpuTypesPkg::*;

  localparam int WAIT_LIMIT = 200;   // Cycles per wait loop.
  localparam logic [5:0] RFUNCTS [10] = '{FN_SLL, FN_SRL, FN_ADDU, FN_SUBU, FN_AND,
                                          FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
  localparam logic [5:0] IOPS [7] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
                                      OP_ORI, OP_XORI, OP_LUI};

  logic        CLK = 1'b0;
  logic        nRST;
  logic        inValid, inReady, retValid, retReady, retWen;
  instrT       instr;
  logic [31:0] incPC, rdat1, rdat2, retData;
  logic [4:0]  retAddr;

  logic [37:0] expQ [$];             // {wen, addr, data} per accepted instruction.
  int          cycQ [$];             // Acceptance cycle.
  logic [31:0] modelMem [DMEM_WORDS];
  int          cycle, errCount, checkCount, testNum, testStartErr;
  bit          bpMode;               // Random retReady when set.
  logic        holdPending, heldWen;
  logic [4:0]  heldAddr;
  logic [31:0] heldData;

  pipelineBackEnd uut (.*);

  always #20 CLK = ~CLK;

  // ####################################################################
  // Reference model
  // ####################################################################
  function automatic logic [37:0] refModel(logic [31:0] ins, logic [31:0] a,
                                           logic [31:0] b, logic [31:0] pc);
    logic [31:0] se, ze, sum, res;
    logic [4:0]  dst;
    logic        wen;
    se  = {{16{ins[15]}}, ins[15:0]};
    ze  = {16'h0000, ins[15:0]};
    sum = a + se;                    // Memory address.
    res = 32'd0;
    dst = ins[20:16];                // rt unless R-type or JAL.
    wen = 1'b1;
    case (ins[31:26])
      OP_RTYPE: begin
        dst = ins[15:11];
        case (ins[5:0])
          FN_SLL:  res = b << ins[10:6];
          FN_SRL:  res = b >> ins[10:6];
          FN_ADDU: res = a + b;
          FN_SUBU: res = a - b;
          FN_AND:  res = a & b;
          FN_OR:   res = a | b;
          FN_XOR:  res = a ^ b;
          FN_NOR:  res = ~(a | b);
          FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
          default: wen = 1'b0;
        endcase
      end
      OP_ADDIU: res = a + se;
      OP_SLTI:  res = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
      OP_SLTIU: res = (a < se) ? 32'd1 : 32'd0;
      OP_ANDI:  res = a & ze;
      OP_ORI:   res = a | ze;
      OP_XORI:  res = a ^ ze;
      OP_LUI:   res = {ins[15:0], 16'h0000};
      OP_LW:    res = modelMem[sum[7:2]];
      OP_SW: begin
        modelMem[sum[7:2]] = b;      // Stores update in program order.
        wen = 1'b0;
      end
      OP_JAL: begin
        dst = LINK_REG;
        res = pc;
      end
      default:  wen = 1'b0;
    endcase
    if (dst == 5'd0) wen = 1'b0;
    return {wen, dst, res};
  endfunction

  // ####################################################################
  // Checker
  // ####################################################################
  task automatic checkValue(input string what, input logic [31:0] got,
                            input logic [31:0] expVal);
    checkCount++;
    if (got !== expVal) begin
      errCount++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, expVal);
    end
  endtask

  always @(posedge CLK) begin : compareRetire
    logic [37:0] expRec;
    int          accCycle;
    if (nRST) begin
      if (holdPending) begin         // Refused record must not move.
        checkValue("stalled retValid", 32'(retValid), 32'd1);
        checkValue("stalled retWen", 32'(retWen), 32'(heldWen));
        checkValue("stalled retAddr", 32'(retAddr), 32'(heldAddr));
        checkValue("stalled retData", retData, heldData);
      end
      if (retValid && !retReady) begin   // No intake while stalled.
        checkValue("stalled inReady", 32'(inReady), 32'd0);
      end
      if (retValid && retReady) begin
        if (expQ.size() == 0) begin
          errCount++;
          $display("retire at %0t ns with no accepted instruction left", $time);
        end else begin
          expRec   = expQ.pop_front();
          accCycle = cycQ.pop_front();
          checkValue("retWen", 32'(retWen), 32'(expRec[37]));
          if (expRec[37]) begin
            checkValue("retAddr", 32'(retAddr), 32'(expRec[36:32]));
            checkValue("retData", retData, expRec[31:0]);
          end
          if (!bpMode) checkValue("retire latency", 32'(cycle - accCycle), 32'd2);
        end
      end
      holdPending = retValid && !retReady;
      heldWen     = retWen;
      heldAddr    = retAddr;
      heldData    = retData;
      if (inValid && inReady) begin
        expQ.push_back(refModel(instr, rdat1, rdat2, incPC));
        cycQ.push_back(cycle);
      end
      cycle++;
    end
  end

  // ####################################################################
  // Stimulus helpers
  // ####################################################################
  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test failures found");
    $finish;
  endtask

  task automatic nextNeg();
    @(negedge CLK);
    retReady = bpMode ? (($urandom % 3) != 0) : 1'b1;
  endtask

  task automatic issue(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b);
    int n;
    nextNeg();
    inValid = 1'b1;
    instr   = ins;
    rdat1   = a;
    rdat2   = b;
    incPC   = $urandom & 32'hFFFF_FFFC;
    n = 0;
    @(posedge CLK);
    while (!inReady) begin           // Held until accepted.
      n++;
      if (n > WAIT_LIMIT) abortRun("timeout: input was never accepted");
      nextNeg();
      @(posedge CLK);
    end
  endtask

  task automatic idle(input int k);
    repeat (k) begin
      nextNeg();
      inValid = 1'b0;
    end
  endtask

  task automatic endTest(input string name);
    int n;
    n = 0;
    idle(1);
    while (expQ.size() != 0) begin
      n++;
      if (n > WAIT_LIMIT) abortRun("timeout: accepted instructions did not all retire");
      idle(1);
    end
    testNum++;
    $display("test %0d %s: %0d errors", testNum, name, errCount - testStartErr);
    testStartErr = errCount;
  endtask

  function automatic logic [31:0] iWord(logic [5:0] op, logic [15:0] imm);
    return {op, 5'($urandom), 5'($urandom), imm};
  endfunction

  function automatic logic [31:0] aluInstr();
    if ($urandom % 2 == 0)
      return {OP_RTYPE, 5'($urandom), 5'($urandom), 5'($urandom), 5'($urandom),
              RFUNCTS[4'($urandom % 10)]};
    return iWord(IOPS[3'($urandom % 7)], 16'($urandom));
  endfunction

  function automatic logic [31:0] mixedInstr();
    int pick;
    pick = $urandom % 10;
    if (pick < 5) return aluInstr();
    if (pick < 7) return iWord(OP_LW, 16'($urandom));
    if (pick < 9) return iWord(OP_SW, 16'($urandom));
    return {OP_JAL, 26'($urandom)};
  endfunction

  // Word k of memory through a random signed offset.
  task automatic memAccess(input logic [5:0] op, input int k, input logic [31:0] d);
    logic [15:0] imm;
    imm = 16'($urandom);
    issue(iWord(op, imm), 32'(k * 4) - {{16{imm[15]}}, imm}, d);
  endtask

  // ####################################################################
  // Test sequence
  // ####################################################################
  initial begin
    void'($urandom(32'hdf7d_fb95));
    nRST = 1'b0;
    inValid = 1'b0;
    instr = '0;
    incPC = '0;
    rdat1 = '0;
    rdat2 = '0;
    retReady = 1'b1;
    bpMode = 1'b0;
    holdPending = 1'b0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    nextNeg();
    checkValue("retValid after reset", 32'(retValid), 32'd0);
    checkValue("inReady after reset", 32'(inReady), 32'd1);
    endTest("reset");

    repeat (200) issue(aluInstr(), $urandom, $urandom);
    endTest("random ALU");

    for (int k = 0; k < DMEM_WORDS; k++)
      memAccess(OP_SW, k, {16'(k * 769), 16'(~k)} ^ 32'h5A3C_96E1);   // Fill by address.
    for (int k = 0; k < 40; k++) begin
      memAccess(OP_SW, k % DMEM_WORDS, $urandom);
      memAccess(OP_LW, k % DMEM_WORDS, $urandom);
      memAccess(OP_LW, int'($urandom % DMEM_WORDS), $urandom);
    end
    endTest("store and load");

    for (int k = 0; k < 6; k++) begin
      issue({OP_JAL, 26'($urandom)}, $urandom, $urandom);
      issue({OP_RTYPE, 5'($urandom), 5'($urandom), 5'd0, 5'd0, FN_ADDU}, $urandom, $urandom);
      issue({OP_ADDIU, 5'($urandom), 5'd0, 16'($urandom)}, $urandom, $urandom);
      issue({6'h3F, 26'($urandom)}, $urandom, $urandom);        // Unknown opcode.
      issue({OP_RTYPE, 20'($urandom), 6'h3F}, $urandom, $urandom);  // Unknown funct.
    end
    endTest("JAL, register 0 and unknown opcodes");

    bpMode = 1'b1;
    for (int k = 0; k < 300; k++) begin
      if ($urandom % 3 == 0) idle(1 + int'($urandom % 3));
      issue(mixedInstr(), $urandom, $urandom);
    end
    endTest("back-pressure");
    bpMode = 1'b0;

    repeat (30) issue(aluInstr(), $urandom, $urandom);
    endTest("two-cycle latency");

    $display("%0d tests, %0d checks, %0d errors", testNum, checkCount, errCount);
    if (errCount == 0) $display("All tests passed!");
    else $display("Test failures found");
    $finish;
  end

endmodule

// ==== build.f ====
hdl/cpuTypesPkg.sv
hdl/pipeRegIf.sv
hdl/controlUnit.sv
hdl/executeStage.sv
hdl/pipeStageReg.sv
hdl/memoryStage.sv
hdl/writebackStage.sv
hdl/pipelineBackEnd.sv
verification/backEndTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the pipeline back-end testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module backEndTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/VbackEndTb)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -qF "All tests passed!"; then
  exit 0
fi
exit 1
